// File: source/controlUnit_defs.svh
`ifndef CONTROL_UNIT_DEFS_SVH
`define CONTROL_UNIT_DEFS_SVH

// Instruction field widths.
`define OPCODE_WIDTH 6
`define OFFSET_WIDTH 16
`define FUNCT_WIDTH 6
`define REG_ADDR_WIDTH 5
`define SHAMT_WIDTH 5

// Step counter width.
`define STEP_WIDTH 3

// Opcodes.
`define OP_RTYPE 6'b000000
`define OP_ADDI 6'b001000
`define OP_RESET 6'b111111

// R-type funct codes.
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_SLL 6'b000000

// Fetch steps.
`define IR_LOAD_STEP 3'd3
`define REG_READ_STEP 3'd4
`define FETCH_LAST_STEP 3'd5

// Last step of each execute phase.
`define ALU_LAST_STEP 3'd1
`define SLL_LAST_STEP 3'd4

`endif

// File: source/ctrlPkg.sv
`include "controlUnit_defs.svh"

package ctrlPkg;

    // R-type view of the low half of the instruction.
    typedef struct packed {
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`SHAMT_WIDTH-1:0]    shamt;
        logic [`FUNCT_WIDTH-1:0]    funct;
    } rFields_t;

    // Low 16 bits, read as R-type fields or as an immediate.
    typedef union packed {
        rFields_t                 rType;
        logic [`OFFSET_WIDTH-1:0] immediate;
    } offsetField_u;

    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0] opcode;
        offsetField_u             offset;
    } instrWord_t;

    typedef enum logic [2:0] {
        classAdd     = 3'd0,
        classSub     = 3'd1,
        classAnd     = 3'd2,
        classAddi    = 3'd3,
        classSll     = 3'd4,
        classHalt    = 3'd5,
        classUnknown = 3'd6
    } instrClass_e;

    typedef enum logic [2:0] {
        phaseFetch = 3'd0,
        phaseAlu   = 3'd1,
        phaseAddi  = 3'd2,
        phaseSll   = 3'd3,
        phaseHalt  = 3'd4
    } phase_e;

    typedef enum logic [2:0] {
        aluNone = 3'b000,
        aluAdd  = 3'b001,
        aluSub  = 3'b010,
        aluAnd  = 3'b011
    } aluOp_e;

    typedef enum logic [1:0] {
        srcBRegB = 2'b00,
        srcBFour = 2'b01,
        srcBImm  = 2'b10
    } srcBSel_e;

    typedef enum logic [1:0] {
        destRt = 2'b00,
        destRd = 2'b01
    } regDest_e;

    typedef enum logic [2:0] {
        shiftNone = 3'b000,
        shiftLoad = 3'b001,
        shiftLeft = 3'b010
    } shiftOp_e;

    // Every datapath enable and select for one cycle.
    typedef struct packed {
        logic     pcWrite;
        logic     irWrite;
        logic     regWrite;
        logic     aWrite;
        logic     bWrite;
        aluOp_e   aluOp;
        logic     aluOutWrite;
        logic     srcASel;
        srcBSel_e srcBSel;
        regDest_e regDest;
        logic     memToRegSel;
        logic     shiftAmtSel;
        logic     shiftSrcSel;
        shiftOp_e shiftOp;
        logic     resetOut;
    } controlWord_t;

endpackage

// File: source/instrDecoder.sv
`include "controlUnit_defs.svh"

module instrDecoder (
    input  ctrlPkg::instrWord_t  instruction,
    output ctrlPkg::instrClass_e instrClass
);

    import ctrlPkg::*;

    rFields_t rFields;

    // Funct is only meaningful under the R-type opcode.
    assign rFields = instruction.offset.rType;

    always_comb begin
        instrClass = classUnknown;
        case (instruction.opcode)
            `OP_RTYPE: begin
                case (rFields.funct)
                    `FN_ADD: begin
                        instrClass = classAdd;
                    end
                    `FN_SUB: begin
                        instrClass = classSub;
                    end
                    `FN_AND: begin
                        instrClass = classAnd;
                    end
                    `FN_SLL: begin
                        instrClass = classSll;
                    end
                    default: begin
                        instrClass = classUnknown;
                    end
                endcase
            end
            `OP_ADDI: begin
                instrClass = classAddi;
            end
            `OP_RESET: begin
                instrClass = classHalt;
            end
            default: begin
                instrClass = classUnknown;
            end
        endcase
    end

endmodule

// File: source/stepSequencer.sv
`include "controlUnit_defs.svh"

module stepSequencer (
    input  logic                    clock,
    input  logic                    reset,
    input  ctrlPkg::instrClass_e    instrClass,
    output ctrlPkg::phase_e         phase,
    output logic [`STEP_WIDTH-1:0]  step,
    output ctrlPkg::aluOp_e         aluOp
);

    import ctrlPkg::*;

    logic [`STEP_WIDTH-1:0] lastStep;
    phase_e                 dispatchPhase;
    aluOp_e                 dispatchAluOp;

    // Final step of the current phase.
    always_comb begin
        case (phase)
            phaseFetch: begin
                lastStep = `FETCH_LAST_STEP;
            end
            phaseAlu, phaseAddi: begin
                lastStep = `ALU_LAST_STEP;
            end
            phaseSll: begin
                lastStep = `SLL_LAST_STEP;
            end
            default: begin
                lastStep = '0;
            end
        endcase
    end

    // Next phase and ALU operation chosen at dispatch.
    always_comb begin
        dispatchAluOp = aluNone;
        case (instrClass)
            classAdd: begin
                dispatchPhase = phaseAlu;
                dispatchAluOp = aluAdd;
            end
            classSub: begin
                dispatchPhase = phaseAlu;
                dispatchAluOp = aluSub;
            end
            classAnd: begin
                dispatchPhase = phaseAlu;
                dispatchAluOp = aluAnd;
            end
            classAddi: begin
                dispatchPhase = phaseAddi;
            end
            classSll: begin
                dispatchPhase = phaseSll;
            end
            classHalt: begin
                dispatchPhase = phaseHalt;
            end
            default: begin
                // unknown instruction goes straight back to fetch
                dispatchPhase = phaseFetch;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= phaseFetch;
            step  <= '0;
            aluOp <= aluNone;
        end else if (phase == phaseHalt) begin
            step <= '0;
        end else if (step == lastStep) begin
            step <= '0;
            if (phase == phaseFetch) begin
                phase <= dispatchPhase;
                aluOp <= dispatchAluOp;
            end else begin
                phase <= phaseFetch;
            end
        end else begin
            step <= step + 1'b1;
        end
    end

endmodule

// File: source/controlWordGen.sv
`include "controlUnit_defs.svh"

module controlWordGen (
    input  logic                    clock,
    input  logic                    reset,
    input  ctrlPkg::phase_e         phase,
    input  logic [`STEP_WIDTH-1:0]  step,
    input  ctrlPkg::aluOp_e         aluOp,
    output ctrlPkg::controlWord_t   control
);

    import ctrlPkg::*;

    controlWord_t nextWord;

    always_comb begin
        nextWord = '0;
        case (phase)
            phaseFetch: begin
                // PC + 4 is formed through the ALU up to the IR load.
                if (step <= `IR_LOAD_STEP) begin
                    nextWord.aluOp   = aluAdd;
                    nextWord.srcBSel = srcBFour;
                end
                if (step == `IR_LOAD_STEP) begin
                    nextWord.pcWrite = 1'b1;
                    nextWord.irWrite = 1'b1;
                end
                if (step == `REG_READ_STEP) begin
                    nextWord.aWrite  = 1'b1;
                    nextWord.bWrite  = 1'b1;
                    nextWord.srcBSel = srcBFour;
                end
            end
            phaseAlu: begin
                nextWord.aluOp       = aluOp;
                nextWord.aluOutWrite = 1'b1;
                nextWord.srcASel     = 1'b1;
                nextWord.srcBSel     = srcBRegB;
                if (step == `ALU_LAST_STEP) begin
                    nextWord.regWrite = 1'b1;
                    nextWord.regDest  = destRd;
                end
            end
            phaseAddi: begin
                nextWord.aluOp       = aluAdd;
                nextWord.aluOutWrite = 1'b1;
                nextWord.srcASel     = 1'b1;
                nextWord.srcBSel     = srcBImm;
                if (step == `ALU_LAST_STEP) begin
                    nextWord.regWrite = 1'b1;
                    nextWord.regDest  = destRt;
                end
            end
            phaseSll: begin
                case (step)
                    3'd0: begin
                        // Load shifter with rt and shamt.
                        nextWord.regDest     = destRd;
                        nextWord.memToRegSel = 1'b1;
                        nextWord.shiftAmtSel = 1'b1;
                        nextWord.shiftSrcSel = 1'b1;
                        nextWord.shiftOp     = shiftLoad;
                    end
                    3'd1: begin
                        nextWord.regDest = destRd;
                        nextWord.shiftOp = shiftLeft;
                    end
                    3'd2, 3'd3: begin
                        nextWord.regWrite    = 1'b1;
                        nextWord.regDest     = destRd;
                        nextWord.memToRegSel = 1'b1;
                    end
                    default: begin
                        nextWord = '0;
                    end
                endcase
            end
            phaseHalt: begin
                nextWord.resetOut = 1'b1;
            end
            default: begin
                nextWord = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            control          <= '0;
            control.resetOut <= 1'b1;
        end else begin
            control <= nextWord;
        end
    end

endmodule

// File: source/controlUnit.sv
`include "controlUnit_defs.svh"

module controlUnit (
    input  logic                  clock,
    input  logic                  reset,
    input  ctrlPkg::instrWord_t   instruction,
    output ctrlPkg::controlWord_t control
);

    import ctrlPkg::*;

    instrClass_e            instrClass;
    phase_e                 phase;
    logic [`STEP_WIDTH-1:0] step;
    aluOp_e                 aluOp;

    instrDecoder i_instrDecoder (
        .instruction (instruction),
        .instrClass  (instrClass)
    );

    stepSequencer i_stepSequencer (
        .clock      (clock),
        .reset      (reset),
        .instrClass (instrClass),
        .phase      (phase),
        .step       (step),
        .aluOp      (aluOp)
    );

    // Word for each phase and step, one cycle behind the sequencer.
    controlWordGen i_controlWordGen (
        .clock   (clock),
        .reset   (reset),
        .phase   (phase),
        .step    (step),
        .aluOp   (aluOp),
        .control (control)
    );

endmodule

// File: dv/controlUnit_assertions.sv
module controlUnit_assertions (
    input logic                  clock,
    input logic                  reset,
    input ctrlPkg::controlWord_t control
);

    logic anyWrite;

    assign anyWrite = control.pcWrite | control.irWrite | control.regWrite
                    | control.aWrite | control.bWrite | control.aluOutWrite;

    // IR load is a one-cycle strobe.
    irWriteSingle: assert property (@(posedge clock) disable iff (reset)
        control.irWrite |=> !control.irWrite)
        else $error("irWrite high on two consecutive cycles");

    regWriteApart: assert property (@(posedge clock) disable iff (reset)
        !(control.regWrite && control.irWrite))
        else $error("regWrite and irWrite high in the same cycle");

    // Halt and reset both block every write.
    resetOutQuiet: assert property (@(posedge clock)
        control.resetOut |-> !anyWrite)
        else $error("write enable high while resetOut is high");

endmodule

bind controlWordGen controlUnit_assertions i_assertions (
    .clock   (clock),
    .reset   (reset),
    .control (control)
);

// File: dv/controlUnit_tb.sv
`include "controlUnit_defs.svh"

module controlUnit_tb;

    import ctrlPkg::*;

    localparam int irTimeout = 20;
    localparam int execTimeout = 12;
    localparam int haltHold = 8;

    logic         clock;
    logic         reset;
    instrWord_t   instruction;
    controlWord_t control;
    controlWord_t current;
    int           errorCount;
    int           testCount;
    int           failCount;
    bit           aborted;

    controlUnit i_dut (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .control     (control)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Fetch words, one per step.
    function automatic controlWord_t fetchWord(input int step);
        controlWord_t word;
        word = '0;
        if (step <= 4) begin
            word.srcBSel = srcBFour;
        end
        if (step <= 3) begin
            word.aluOp = aluAdd;
        end
        if (step == 3) begin
            word.pcWrite = 1'b1;
            word.irWrite = 1'b1;
        end
        if (step == 4) begin
            word.aWrite = 1'b1;
            word.bWrite = 1'b1;
        end
        return word;
    endfunction

    function automatic controlWord_t execWord(input instrClass_e cls, input int step);
        controlWord_t word;
        word = '0;
        case (cls)
            classAdd, classSub, classAnd, classAddi: begin
                word.aluOp = aluAdd;
                if (cls == classSub) begin
                    word.aluOp = aluSub;
                end
                if (cls == classAnd) begin
                    word.aluOp = aluAnd;
                end
                word.aluOutWrite = 1'b1;
                word.srcASel = 1'b1;
                word.srcBSel = (cls == classAddi) ? srcBImm : srcBRegB;
                word.regWrite = (step == 1);
                // Addi writes rt, the R-type ops write rd.
                word.regDest = (step == 1 && cls != classAddi) ? destRd : destRt;
            end
            classSll: begin
                word.regDest = (step < 4) ? destRd : destRt;
                word.regWrite = (step == 2 || step == 3);
                word.memToRegSel = (step == 0 || step == 2 || step == 3);
                word.shiftAmtSel = (step == 0);
                word.shiftSrcSel = (step == 0);
                if (step == 0) begin
                    word.shiftOp = shiftLoad;
                end
                if (step == 1) begin
                    word.shiftOp = shiftLeft;
                end
            end
            classHalt: begin
                word.resetOut = 1'b1;
            end
            default: begin
                word = '0;
            end
        endcase
        return word;
    endfunction

    function automatic int execLength(input instrClass_e cls);
        case (cls)
            classAdd, classSub, classAnd, classAddi: return 2;
            classSll: return 5;
            default: return 0;
        endcase
    endfunction

    // Opcode and funct table.
    function automatic instrClass_e classRule(input instrWord_t word);
        if (word.opcode == `OP_ADDI) return classAddi;
        if (word.opcode == `OP_RESET) return classHalt;
        if (word.opcode != `OP_RTYPE) return classUnknown;
        case (word.offset.rType.funct)
            `FN_ADD: return classAdd;
            `FN_SUB: return classSub;
            `FN_AND: return classAnd;
            `FN_SLL: return classSll;
            default: return classUnknown;
        endcase
    endfunction

    // Class as seen from the execute sequence.
    function automatic instrClass_e inferClass(input int length, input controlWord_t first,
                                               input bit halted);
        if (halted) return classHalt;
        if (length == 5) return classSll;
        if (length != 2) return classUnknown;
        if (first.srcBSel == srcBImm) return classAddi;
        case (first.aluOp)
            aluAdd: return classAdd;
            aluSub: return classSub;
            aluAnd: return classAnd;
            default: return classUnknown;
        endcase
    endfunction

    function automatic bit classFromName(input string text, output instrClass_e cls);
        cls = classUnknown;
        case (text)
            "add": cls = classAdd;
            "sub": cls = classSub;
            "and": cls = classAnd;
            "addi": cls = classAddi;
            "sll": cls = classSll;
            "halt": cls = classHalt;
            "unknown": cls = classUnknown;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    task automatic checkControl(input string label, input controlWord_t expected,
                                input controlWord_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h actual %h", label, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkClass(input string label, input instrClass_e expected,
                              input instrClass_e actual);
        if (actual !== expected) begin
            $display("ERROR %s class: expected %s actual %s", label, expected.name(),
                     actual.name());
            errorCount++;
        end
    endtask

    task automatic waitFetchStart();
        controlWord_t resetWord;
        resetWord = '0;
        resetWord.resetOut = 1'b1;
        for (int cycles = 0; cycles < irTimeout; cycles++) begin
            @(negedge clock);
            current = control;
            if (!current.resetOut) return;
            // Only resetOut may be high while reset is held.
            checkControl("reset", resetWord, current);
        end
        $display("control unit did not leave reset within %0d cycles", irTimeout);
        aborted = 1'b1;
    endtask

    // Halt must hold with no writes until the next reset.
    task automatic holdHalt(input string name);
        checkControl({name, " halt"}, execWord(classHalt, 0), current);
        for (int i = 0; i < haltHold; i++) begin
            @(negedge clock);
            checkControl($sformatf("%s halt hold %0d", name, i), execWord(classHalt, 0), control);
        end
        @(posedge clock);
        reset <= 1'b1;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        waitFetchStart();
    endtask

    task automatic runTest(input instrWord_t word, input string className);
        string        name;
        int           irIndex;
        int           errorsBefore;
        bit           stopped;
        instrClass_e  fileClass;
        instrClass_e  predicted;
        controlWord_t fetchSeen[$];
        controlWord_t execSeen[$];
        name = $sformatf("t%0d %s %h", testCount, className, word);
        errorsBefore = errorCount;
        if (!classFromName(className, fileClass)) begin
            $display("test %s: class name in the test data is not recognized", name);
            errorCount++;
        end
        fetchSeen.push_back(current);
        irIndex = current.irWrite ? 0 : -1;
        for (int cycles = 0; cycles < irTimeout && irIndex < 0; cycles++) begin
            @(negedge clock);
            fetchSeen.push_back(control);
            if (control.irWrite) irIndex = fetchSeen.size() - 1;
        end
        if (irIndex < 0) begin
            $display("test %s: irWrite never rose within %0d cycles", name, irTimeout);
            aborted = 1'b1;
            return;
        end
        if (irIndex != int'(`IR_LOAD_STEP)) begin
            $display("ERROR %s irWrite cycle: expected %0d actual %0d", name, `IR_LOAD_STEP,
                     irIndex);
            errorCount++;
        end
        // The instruction register loads on the edge after irWrite.
        @(posedge clock);
        instruction <= word;
        repeat (2) begin
            @(negedge clock);
            fetchSeen.push_back(control);
        end
        for (int i = 0; i <= int'(`FETCH_LAST_STEP) && i < fetchSeen.size(); i++) begin
            checkControl($sformatf("%s fetch %0d", name, i), fetchWord(i), fetchSeen[i]);
        end
        stopped = 1'b0;
        for (int cycles = 0; cycles < execTimeout && !stopped; cycles++) begin
            @(negedge clock);
            current = control;
            if (current.resetOut || current == fetchWord(0)) begin
                stopped = 1'b1;
            end else begin
                execSeen.push_back(current);
            end
        end
        if (!stopped) begin
            $display("test %s: no return to fetch within %0d cycles", name, execTimeout);
            aborted = 1'b1;
            return;
        end
        predicted = classRule(word);
        if (execSeen.size() != execLength(predicted)) begin
            $display("ERROR %s execute length: expected %0d actual %0d", name,
                     execLength(predicted), execSeen.size());
            errorCount++;
        end
        for (int i = 0; i < execSeen.size() && i < execLength(predicted); i++) begin
            checkControl($sformatf("%s exec %0d", name, i), execWord(predicted, i), execSeen[i]);
        end
        checkClass(name, fileClass,
                   inferClass(execSeen.size(), (execSeen.size() > 0) ? execSeen[0] : '0,
                              current.resetOut));
        if (current.resetOut) holdHalt(name);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %s: pass", name);
        end else begin
            failCount++;
            $display("test %s: fail", name);
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        string       line;
        string       className;
        logic [21:0] bits;
        reset = 1'b1;
        instruction = '0;
        errorCount = 0;
        testCount = 0;
        failCount = 0;
        aborted = 1'b0;
        fd = $fopen("dv/controlUnit_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            aborted = 1'b1;
        end
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        waitFetchStart();
        while (!aborted && $fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%h %s", bits, className);
            if (fields == 2) runTest(bits, className);
        end
        if (fd != 0) $fclose(fd);
        $display("%0d tests, %0d passed, %0d failed, %0d errors", testCount,
                 testCount - failCount, failCount, errorCount);
        if (!aborted && errorCount == 0 && testCount > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: dv/controlUnit_testdata.txt
# instruction word in hex (opcode[21:16], then rd/shamt/funct or a 16-bit immediate)
# expected class: add sub and addi sll halt unknown
001820 add
002822 sub
003824 and
080005 addi
001100 sll
0018e0 add
08ffff addi
080020 addi
00ffc0 sll
00102a unknown
230010 unknown
3f0000 halt
002022 sub
3e0000 unknown
00f824 and
080100 addi
000000 sll
000001 unknown
001020 add
002000 sll
3f1234 halt
0e0000 unknown
09ffff unknown
003fe2 sub
001824 and
080000 addi

// File: flist.f
+incdir+source
source/ctrlPkg.sv
source/instrDecoder.sv
source/stepSequencer.sv
source/controlWordGen.sv
source/controlUnit.sv
dv/controlUnit_assertions.sv
dv/controlUnit_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module controlUnit_tb -o controlUnit_sim

# The simulator may stop on an assertion, so the log decides the result.
./obj_dir/controlUnit_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
